//--- audio_mix.f
verilog/audio_mix_pkg.sv
verilog/sample_capture.sv
verilog/linear_interp.sv
verilog/psg_fm_sum.sv
verilog/volume_scale.sv
verilog/audio_mix_top.sv
test/audio_mix_assert.sv
test/audio_mix_tb.sv

//--- Bender.yml
package:
  name: audio_mix

sources:
  - verilog/audio_mix_pkg.sv
  - verilog/sample_capture.sv
  - verilog/linear_interp.sv
  - verilog/psg_fm_sum.sv
  - verilog/volume_scale.sv
  - verilog/audio_mix_top.sv
  - target: test
    files:
      - test/audio_mix_assert.sv
      - test/audio_mix_tb.sv

//--- test/audio_mix_testdata.txt
4 100 -100 400 1 0 0
4 -50 60 400 0 660 -340
4 20 20 808 1 -118 232
7 -256 255 fff 1 2968 3848
7 255 -256 000 1 -4456 15984
7 10 -10 123 0 9168 -7184
6 -1 1 0f0 1 1220 -1224
6 77 -77 3a8 1 168 128
5 -128 127 7ff 0 1074 -462
5 64 32 200 1 -1068 1174
3 -200 -200 555 1 136 183
3 150 -150 aaa 1 -354 -370
2 0 0 800 1 254 -121
2 -33 33 040 1 138 63
2 99 -99 c00 0 -23 59
1 -7 7 100 1 58 -58
1 200 -200 9f8 1 13 -3
0 -150 150 0ff 1 87 -37
0 40 -40 e00 1 -27 41
0 -90 -90 333 0 38 32

//--- test/audio_mix_tb.sv
// testbench for the mixer with clock, reset, file and random frames, reference model, checks, report
`timescale 1ns/1ns

module audio_mix_tb;
	import audio_mix_pkg::*;

	localparam string DATA_FILE = "test/audio_mix_testdata.txt";
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_FRAMES = 8;
	// outputs this close to a volume change are left unchecked
	localparam int VOL_SETTLE = 60;
	// the first output is registered 5 cycles after the edge that drives sample
	// and is seen here one edge later
	localparam int FIRST_OUT_DELAY = 6;

	logic clk;
	logic rst_n;
	logic sample;
	logic [2:0] volume;
	fm_t left_in;
	fm_t right_in;
	logic [11:0] psg;
	logic enable_psg;
	out_t left_out;
	out_t right_out;
	logic sample_out;

	// frames read from the data file with the expected pair of each frame's first output
	int f_vol[$];
	int f_left[$];
	int f_right[$];
	int f_psg[$];
	int f_en[$];
	int f_exp_l[$];
	int f_exp_r[$];

	// expected unscaled outputs of the second stage and the cycle each should appear in
	int exp_left_q[$];
	int exp_right_q[$];
	int due_q[$];

	// reference histories of the first stage inputs and the second stage inputs
	int pl = 0;
	int pr = 0;
	int pq = 0;
	int ml = 0;
	int mr = 0;

	int cycle = 0;
	int cycle_limit = 0;
	int vol_change_cycle = -1000;
	int cur_volume = 0;
	int mismatch_count = 0;
	int other_errors = 0;
	integer seed = 32'h21dc_79a9;

	audio_mix_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.sample     (sample),
		.volume     (volume),
		.left_in    (left_in),
		.right_in   (right_in),
		.psg        (psg),
		.enable_psg (enable_psg),
		.left_out   (left_out),
		.right_out  (right_out),
		.sample_out (sample_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// levels 7 down to 2 shift left by 5 down to 0, levels 1 and 0 shift right by 1 and 2
	// the output keeps bits 19 to 4, which is a further arithmetic shift by 4
	function automatic int scaled_output(input int mix4, input int level);
		int amp;
		if (level >= 2) begin
			amp = mix4 * (1 << (level - 2));
		end else begin
			amp = mix4 >>> (2 - level);
		end
		return amp >>> 4;
	endfunction

	task automatic load_frames();
		int fd;
		int v;
		int l;
		int r;
		int p;
		int e;
		int xl;
		int xr;
		fd = $fopen(DATA_FILE, "r");
		assert (fd != 0) else begin
			other_errors++;
			$display("cannot open the data file %s", DATA_FILE);
		end
		if (fd != 0) begin
			while ($fscanf(fd, "%d %d %d %h %d %d %d\n", v, l, r, p, e, xl, xr) == 7) begin
				f_vol.push_back(v);
				f_left.push_back(l);
				f_right.push_back(r);
				f_psg.push_back(p);
				f_en.push_back(e);
				f_exp_l.push_back(xl);
				f_exp_r.push_back(xr);
			end
			$fclose(fd);
		end
	endtask

	// output k of a burst is R*P + k*(N-P); the mix adds the PSG shifted down by 2
	task automatic push_frame_model(input int nl, input int nr, input int nq, input int start);
		int k;
		int j;
		int psg6;
		int mix_l;
		int mix_r;
		for (k = 0; k < RATIO_FIRST; k++) begin
			psg6 = RATIO_FIRST * pq + k * (nq - pq);
			mix_l = RATIO_FIRST * pl + k * (nl - pl) + (psg6 >>> PSG_ATT_SHIFT);
			mix_r = RATIO_FIRST * pr + k * (nr - pr) + (psg6 >>> PSG_ATT_SHIFT);
			for (j = 0; j < RATIO_SECOND; j++) begin
				exp_left_q.push_back(RATIO_SECOND * ml + j * (mix_l - ml));
				exp_right_q.push_back(RATIO_SECOND * mr + j * (mix_r - mr));
				due_q.push_back(start + FIRST_OUT_DELAY + k * STEP_FIRST + j * STEP_SECOND);
			end
			ml = mix_l;
			mr = mix_r;
		end
		pl = nl;
		pr = nr;
		pq = nq;
	endtask

	// one sample strobe, then idle until the frame period is over
	task automatic drive_frame(input int vol, input int l, input int r, input int p,
		input int en, input int has_ref, input int ref_l, input int ref_r);
		int first;
		@(posedge clk);
		if (vol != cur_volume) begin
			vol_change_cycle <= cycle;
			cur_volume = vol;
		end
		volume <= 3'(vol);
		left_in <= fm_t'(l);
		right_in <= fm_t'(r);
		psg <= 12'(p);
		enable_psg <= (en != 0);
		sample <= 1'b1;
		first = due_q.size();
		// a silenced PSG enters as zero, otherwise its upper 9 bits
		push_frame_model(l, r, (en != 0) ? (p >> 3) : 0, cycle);
		if (has_ref != 0) begin
			assert (scaled_output(exp_left_q[first], vol) == ref_l &&
				scaled_output(exp_right_q[first], vol) == ref_r) else begin
				other_errors++;
				$display("data file pair %0d %0d disagrees with the reference model", ref_l, ref_r);
			end
		end
		@(posedge clk);
		sample <= 1'b0;
		repeat (FRAME_CYCLES - 2) @(posedge clk);
	endtask

	task automatic check_output();
		int exp_l;
		int exp_r;
		int due;
		assert (due_q.size() != 0) else begin
			other_errors++;
			$display("%0t: sample_out pulsed when no output was expected", $time);
		end
		if (due_q.size() != 0) begin
			exp_l = scaled_output(exp_left_q.pop_front(), int'(volume));
			exp_r = scaled_output(exp_right_q.pop_front(), int'(volume));
			due = due_q.pop_front();
			assert (cycle == due) else begin
				other_errors++;
				$display("%0t: output strobe came in cycle %0d instead of cycle %0d",
					$time, cycle, due);
			end
			if (cycle - vol_change_cycle >= VOL_SETTLE) begin
				assert (int'(left_out) == exp_l) else begin
					mismatch_count++;
					$display("Mismatch at %0t: left_out expected %0d, actual %0d",
						$time, exp_l, left_out);
				end
				assert (int'(right_out) == exp_r) else begin
					mismatch_count++;
					$display("Mismatch at %0t: right_out expected %0d, actual %0d",
						$time, exp_r, right_out);
				end
			end
		end
	endtask

	task automatic finish_run();
		$display("closing report: %0d mismatches, %0d other errors", mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	// cycle count and output checks share the sampling edge
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (sample_out) begin
			check_output();
		end
	end

	initial begin
		int i;
		int n;
		logic [31:0] rnd_a;
		logic [31:0] rnd_b;
		load_frames();
		cycle_limit = (f_vol.size() + RANDOM_FRAMES + 2) * FRAME_CYCLES + RESET_CYCLES + 100;
		cur_volume = (f_vol.size() != 0) ? f_vol[0] : 0;
		rst_n = 1'b0;
		sample = 1'b0;
		volume = 3'(cur_volume);
		left_in = '0;
		right_in = '0;
		psg = '0;
		enable_psg = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		// a few idle cycles in which sample_out has to stay low
		repeat (4) @(posedge clk);
		for (i = 0; i < f_vol.size(); i++) begin
			drive_frame(f_vol[i], f_left[i], f_right[i], f_psg[i], f_en[i], 1,
				f_exp_l[i], f_exp_r[i]);
		end
		// random frames hold the last volume from the file
		for (i = 0; i < RANDOM_FRAMES; i++) begin
			rnd_a = $random(seed);
			rnd_b = $random(seed);
			drive_frame(cur_volume, $signed(rnd_a[8:0]), $signed(rnd_b[8:0]), rnd_a[20:9],
				rnd_b[9], 0, 0, 0);
		end
		// the tail of the last frame still runs after its period
		n = 0;
		while (due_q.size() != 0 && n < FRAME_CYCLES) begin
			@(posedge clk);
			n++;
		end
		repeat (8) @(posedge clk);
		assert (due_q.size() == 0) else begin
			other_errors++;
			$display("%0d expected output strobes never arrived", due_q.size());
		end
		finish_run();
	end

	initial begin
		@(posedge clk);
		while (cycle < cycle_limit) @(posedge clk);
		other_errors++;
		$display("run timed out after %0d cycles", cycle);
		finish_run();
	end

endmodule

//--- test/audio_mix_assert.sv
// concurrent assertions on the strobe timing of the mixer, and their bind into the top level
`timescale 1ns/1ns

module audio_mix_assert (
	input logic clk,
	input logic rst_n,
	input logic cap_strobe,
	input logic fm6_strobe,
	input logic mix_strobe,
	input logic sample_out
);

	// output strobes are single pulses, at least 2 cycles apart
	single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		sample_out |=> !sample_out)
		else $error("sample_out stayed high for two consecutive cycles");

	// reset keeps the output strobe quiet
	quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !sample_out)
		else $error("sample_out went high while reset was active");

	// the first interpolator starts its burst one cycle after the capture
	// and the previous burst has long ended by then
	first_stage_start: assert property (@(posedge clk) disable iff (!rst_n)
		cap_strobe |-> !fm6_strobe ##1 fm6_strobe)
		else $error("fm6_strobe did not rise one cycle after cap_strobe");

	// the adder passes every strobe on with one cycle of delay
	sum_follows: assert property (@(posedge clk) disable iff (!rst_n)
		fm6_strobe |=> mix_strobe)
		else $error("mix_strobe missing one cycle after fm6_strobe");

	sum_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!fm6_strobe |=> !mix_strobe)
		else $error("mix_strobe high without fm6_strobe one cycle earlier");

endmodule

bind audio_mix_top audio_mix_assert i_assert (
	.clk        (clk),
	.rst_n      (rst_n),
	.cap_strobe (cap_strobe),
	.fm6_strobe (fm6_strobe),
	.mix_strobe (mix_strobe),
	.sample_out (sample_out)
);

//--- verilog/audio_mix_top.sv
// top level of the mixer: capture, interpolate by 6, PSG sum, interpolate by 4, volume
`timescale 1ns/1ns

module audio_mix_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                sample,
	input  logic [2:0]          volume,
	input  audio_mix_pkg::fm_t  left_in,
	input  audio_mix_pkg::fm_t  right_in,
	input  logic [11:0]         psg,
	input  logic                enable_psg,
	output audio_mix_pkg::out_t left_out,
	output audio_mix_pkg::out_t right_out,
	output logic                sample_out
);
	import audio_mix_pkg::*;

	fm_t cap_left;
	fm_t cap_right;
	psg_t cap_psg;
	logic cap_strobe;

	fm6_t fm6_left;
	fm6_t fm6_right;
	psg6_t psg6;
	logic fm6_strobe;

	mix_t mix_left;
	mix_t mix_right;
	logic mix_strobe;

	mix4_t mix4_left;
	mix4_t mix4_right;
	logic mix4_strobe;

	sample_capture i_capture (
		.clk        (clk),
		.rst_n      (rst_n),
		.sample     (sample),
		.left_in    (left_in),
		.right_in   (right_in),
		.psg        (psg),
		.enable_psg (enable_psg),
		.cap_left   (cap_left),
		.cap_right  (cap_right),
		.cap_psg    (cap_psg),
		.cap_strobe (cap_strobe)
	);

	// first stage raises the rate by 6 on the FM pair and the PSG
	// all three run in lockstep, so only the left strobe is taken
	linear_interp #(
		.in_t  (fm_t),
		.out_t (fm6_t),
		.RATIO (RATIO_FIRST),
		.STEP  (STEP_FIRST)
	) i_interp6_left (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_strobe  (cap_strobe),
		.in_value   (cap_left),
		.out_value  (fm6_left),
		.out_strobe (fm6_strobe)
	);

	linear_interp #(
		.in_t  (fm_t),
		.out_t (fm6_t),
		.RATIO (RATIO_FIRST),
		.STEP  (STEP_FIRST)
	) i_interp6_right (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_strobe  (cap_strobe),
		.in_value   (cap_right),
		.out_value  (fm6_right),
		.out_strobe ()
	);

	linear_interp #(
		.in_t  (psg_t),
		.out_t (psg6_t),
		.RATIO (RATIO_FIRST),
		.STEP  (STEP_FIRST)
	) i_interp6_psg (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_strobe  (cap_strobe),
		.in_value   (cap_psg),
		.out_value  (psg6),
		.out_strobe ()
	);

	psg_fm_sum i_sum (
		.clk        (clk),
		.rst_n      (rst_n),
		.fm_strobe  (fm6_strobe),
		.fm_left    (fm6_left),
		.fm_right   (fm6_right),
		.psg_value  (psg6),
		.mix_left   (mix_left),
		.mix_right  (mix_right),
		.mix_strobe (mix_strobe)
	);

	// second stage raises the rate by 4 on the mixed pair
	// each burst of 4 ends well before the next mixed sample
	linear_interp #(
		.in_t  (mix_t),
		.out_t (mix4_t),
		.RATIO (RATIO_SECOND),
		.STEP  (STEP_SECOND)
	) i_interp4_left (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_strobe  (mix_strobe),
		.in_value   (mix_left),
		.out_value  (mix4_left),
		.out_strobe (mix4_strobe)
	);

	linear_interp #(
		.in_t  (mix_t),
		.out_t (mix4_t),
		.RATIO (RATIO_SECOND),
		.STEP  (STEP_SECOND)
	) i_interp4_right (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_strobe  (mix_strobe),
		.in_value   (mix_right),
		.out_value  (mix4_right),
		.out_strobe ()
	);

	volume_scale i_volume (
		.clk        (clk),
		.rst_n      (rst_n),
		.volume     (volume),
		.in_strobe  (mix4_strobe),
		.in_left    (mix4_left),
		.in_right   (mix4_right),
		.left_out   (left_out),
		.right_out  (right_out),
		.sample_out (sample_out)
	);

endmodule

//--- verilog/volume_scale.sv
// output stage that applies the 3-bit volume shift and selects the 16 output bits
`timescale 1ns/1ns

module volume_scale (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [2:0]           volume,
	input  logic                 in_strobe,
	input  audio_mix_pkg::mix4_t in_left,
	input  audio_mix_pkg::mix4_t in_right,
	output audio_mix_pkg::out_t  left_out,
	output audio_mix_pkg::out_t  right_out,
	output logic                 sample_out
);
	import audio_mix_pkg::*;

	amp_t amp_left;
	amp_t amp_right;

	// eight-step shift table, two steps below unity and five above
	function automatic amp_t scale(input mix4_t value, input logic [2:0] level);
		amp_t wide;
		wide = amp_t'(value);
		case (level)
			3'd7: scale = wide <<< 5;
			3'd6: scale = wide <<< 4;
			3'd5: scale = wide <<< 3;
			3'd4: scale = wide <<< 2;
			3'd3: scale = wide <<< 1;
			3'd2: scale = wide;
			3'd1: scale = wide >>> 1;
			default: scale = wide >>> 2;
		endcase
	endfunction

	// volume is live, so a change takes effect on the very next output
	assign amp_left = scale(in_left, volume);
	assign amp_right = scale(in_right, volume);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			left_out <= '0;
			right_out <= '0;
			sample_out <= 1'b0;
		end else begin
			sample_out <= in_strobe;
			// the low 4 bits of the scaled value are dropped
			if (in_strobe) begin
				left_out <= amp_left[19:4];
				right_out <= amp_right[19:4];
			end
		end
	end

endmodule

//--- verilog/psg_fm_sum.sv
// adder stage that mixes the attenuated PSG into both interpolated FM channels
`timescale 1ns/1ns

module psg_fm_sum (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 fm_strobe,
	input  audio_mix_pkg::fm6_t  fm_left,
	input  audio_mix_pkg::fm6_t  fm_right,
	input  audio_mix_pkg::psg6_t psg_value,
	output audio_mix_pkg::mix_t  mix_left,
	output audio_mix_pkg::mix_t  mix_right,
	output logic                 mix_strobe
);
	import audio_mix_pkg::*;

	// PSG after attenuation, same scale as the FM channels
	psg6_t psg_att;

	// arithmetic shift, although the PSG stream never goes negative
	assign psg_att = psg_value >>> PSG_ATT_SHIFT;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mix_left <= '0;
			mix_right <= '0;
			mix_strobe <= 1'b0;
		end else begin
			mix_strobe <= fm_strobe;
			// the PSG strobe matches the FM strobe, so one strobe times both sums
			if (fm_strobe) begin
				// FM is sign-extended by one bit before the add
				mix_left <= mix_t'(fm_left) + mix_t'(psg_att);
				mix_right <= mix_t'(fm_right) + mix_t'(psg_att);
			end
		end
	end

	// the widest sum is 1530 + 766, well inside 13 signed bits
	// the most negative is the bare FM minimum of -1536

endmodule

//--- verilog/linear_interp.sv
// single-channel linear interpolator with parameterized sample types, ratio and output step
`timescale 1ns/1ns

module linear_interp #(
	parameter type in_t = audio_mix_pkg::fm_t,
	parameter type out_t = audio_mix_pkg::fm6_t,
	parameter int  RATIO = audio_mix_pkg::RATIO_FIRST,
	parameter int  STEP = audio_mix_pkg::STEP_FIRST
) (
	input  logic clk,
	input  logic rst_n,
	input  logic in_strobe,
	input  in_t  in_value,
	output out_t out_value,
	output logic out_strobe
);
	// phase holds the outputs still owed in the current burst
	localparam int PHASE_W = $clog2(RATIO + 1);
	// count holds the cycles left until the next output of the burst
	localparam int COUNT_W = $clog2(STEP + 1);

	// previous input P, zero after reset
	in_t prev;
	// increment N-P, added once per output after the first
	out_t delta;
	logic [PHASE_W-1:0] phase;
	logic [COUNT_W-1:0] count;
	logic step_due;

	// a further output is due when outputs remain and the step has run out
	assign step_due = (phase != '0) && (count == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prev <= '0;
			delta <= '0;
			out_value <= '0;
			phase <= '0;
			count <= '0;
			out_strobe <= 1'b0;
		end else if (in_strobe) begin
			// output 0 is R*P, so the burst starts at the previous sample
			// the result carries a gain of R, which the wider out_t absorbs
			out_value <= out_t'(RATIO) * out_t'(prev);
			// difference taken at output width so that N-P cannot overflow
			delta <= out_t'(in_value) - out_t'(prev);
			prev <= in_value;
			phase <= PHASE_W'(RATIO - 1);
			count <= COUNT_W'(STEP - 1);
			out_strobe <= 1'b1;
		end else if (step_due) begin
			// output k equals R*P + k*(N-P), built up one delta at a time
			out_value <= out_value + delta;
			phase <= phase - 1'b1;
			count <= COUNT_W'(STEP - 1);
			out_strobe <= 1'b1;
		end else begin
			out_strobe <= 1'b0;
			// count keeps running down between outputs of the burst
			if (count != '0) begin
				count <= count - 1'b1;
			end
		end
	end

	// the running sum never wraps because every output is a weighted mean of P and N
	// times R, and out_t is sized for that range by the caller

	// a new input strobe restarts the burst, so the caller spaces strobes
	// at least RATIO*STEP cycles apart

endmodule

//--- verilog/sample_capture.sv
// input register stage for the FM pair and the gated PSG level
`timescale 1ns/1ns

module sample_capture (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                sample,
	input  audio_mix_pkg::fm_t  left_in,
	input  audio_mix_pkg::fm_t  right_in,
	input  logic [11:0]         psg,
	input  logic                enable_psg,
	output audio_mix_pkg::fm_t  cap_left,
	output audio_mix_pkg::fm_t  cap_right,
	output audio_mix_pkg::psg_t cap_psg,
	output logic                cap_strobe
);
	import audio_mix_pkg::*;

	// the PSG level is unsigned, so it enters the signed chain with a zero sign bit
	// only its upper 9 bits are kept
	psg_t psg_gated;

	// a silenced PSG contributes nothing to the mix
	assign psg_gated = enable_psg ? psg_t'({1'b0, psg[11:3]}) : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cap_left <= '0;
			cap_right <= '0;
			cap_psg <= '0;
			cap_strobe <= 1'b0;
		end else begin
			// one-cycle strobe marks the newly held frame
			cap_strobe <= sample;
			// values are held between strobes, the interpolators read them only once
			if (sample) begin
				cap_left <= left_in;
				cap_right <= right_in;
				cap_psg <= psg_gated;
			end
		end
	end

endmodule

//--- verilog/audio_mix_pkg.sv
// sample types, interpolation ratios and step lengths, frame and PSG attenuation constants
package audio_mix_pkg;

	// one FM channel sample as delivered by the operator accumulator
	typedef logic signed [8:0] fm_t;

	// PSG stream entering interpolation
	// the upper 9 bits of the gated level sit under a zero sign bit
	typedef logic signed [9:0] psg_t;

	// FM channel after the first interpolator, carrying its gain of 6
	typedef logic signed [11:0] fm6_t;

	// PSG after the first interpolator, gain of 6 on a 10-bit input
	typedef logic signed [12:0] psg6_t;

	// FM plus attenuated PSG, one bit of headroom over fm6_t
	typedef logic signed [12:0] mix_t;

	// mixed channel after the second interpolator, gain of 4
	typedef logic signed [14:0] mix4_t;

	// volume-scaled value; the largest left shift of 5 just fits
	typedef logic signed [19:0] amp_t;

	// final output sample, taken from the top of amp_t
	typedef logic signed [15:0] out_t;

	// the first interpolation stage gives 6 outputs per input at 8-cycle spacing
	localparam int RATIO_FIRST = 6;
	localparam int STEP_FIRST = 8;

	// the second interpolation stage gives 4 outputs per input at 2-cycle spacing
	localparam int RATIO_SECOND = 4;
	localparam int STEP_SECOND = 2;

	// shortest spacing of input strobes equals ratio times step of either stage
	localparam int FRAME_CYCLES = 48;

	// the PSG is brought down by a factor of 4 before it joins the FM channels
	localparam int PSG_ATT_SHIFT = 2;

endpackage
